// ==== verilog/report_pkg.sv ====
package report_pkg;

        // uart timing
        localparam int CLK_FREQ_HZ  = 50_000_000;
        localparam int BAUD_RATE    = 115_200;
        localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
        localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

        // report layout
        localparam int NUM_RECORDS = 3;
        localparam int REC_IDX_W   = $clog2(NUM_RECORDS);
        localparam int LABEL_LEN   = 21;
        localparam int LABEL_OFS   = 3;                         // tag byte + two spaces
        localparam int RECORD_LEN  = LABEL_OFS + LABEL_LEN + 2; // ends in cr lf
        localparam int POS_W       = $clog2(RECORD_LEN);
        localparam int NUM_LABELS  = 14;

        // idle clocks after a report, kept short for simulation
        localparam int REPORT_GAP_CYCLES = 2000;
        localparam int GAP_CNT_W         = $clog2(REPORT_GAP_CYCLES);

        typedef logic [3:0] class_code_t;

        typedef struct packed {
                logic [7:0]  tag;
                class_code_t code;
        } report_rec_t;

        typedef report_rec_t [NUM_RECORDS-1:0] report_set_t;

        typedef struct packed {
                logic       valid;
                logic [7:0] data;
        } tx_req_t;

        // character 0 sits in the first element
        typedef logic [0:LABEL_LEN-1][7:0] label_t;

        // sized terminal counts
        localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
        localparam logic [REC_IDX_W-1:0]  REC_LAST  = REC_IDX_W'(NUM_RECORDS - 1);
        localparam logic [POS_W-1:0]      POS_LAST  = POS_W'(RECORD_LEN - 1);
        localparam logic [POS_W-1:0]      POS_LABEL = POS_W'(LABEL_OFS);
        localparam logic [POS_W-1:0]      CHAR_CR   = POS_W'(LABEL_LEN);
        localparam logic [POS_W-1:0]      CHAR_LF   = POS_W'(LABEL_LEN + 1);
        localparam logic [GAP_CNT_W-1:0]  GAP_LAST  = GAP_CNT_W'(REPORT_GAP_CYCLES - 1);
        localparam class_code_t           CODE_LAST = class_code_t'(NUM_LABELS - 1);

        // fruit labels, padded to LABEL_LEN
        localparam label_t LABEL_TABLE [0:NUM_LABELS-1] = '{
                {LABEL_LEN{" "}},
                {"red apple", {12{" "}}},
                {"red", {4{" "}}, "orange", {8{" "}}},
                {"yellow pear", {10{" "}}},
                {" red", {3{" "}}, "pitaya", {8{" "}}},
                {"yellow", {2{" "}}, "banna", {8{" "}}},
                {"purple", {2{" "}}, "grape", {8{" "}}},
                {"yellow", {2{" "}}, "mango", {8{" "}}},
                {"green", {3{" "}}, "mango", {8{" "}}},
                {"brown", {3{" "}}, "kiwi", {3{" "}}, "fruit", " "},
                {"green", {2{" "}}, "apple", {9{" "}}},
                {"red mangosteen", {7{" "}}},
                {"green", {2{" "}}, "pear", {10{" "}}},
                {"maroon", {2{" "}}, "fig", {10{" "}}}
        };

endpackage

// ==== verilog/label_rom.sv ====
`timescale 1ns/1ns

module label_rom (
        input  report_pkg::class_code_t         code,
        input  logic [report_pkg::POS_W-1:0]    char_pos,
        output logic [7:0]                      label_char
);

        logic code_ok;
        logic in_label;

        assign code_ok  = code <= report_pkg::CODE_LAST;
        assign in_label = char_pos < report_pkg::CHAR_CR;

        // line ending comes from here too
        always_comb begin
                if (char_pos == report_pkg::CHAR_CR) begin
                        label_char = 8'h0d;
                end else if (char_pos == report_pkg::CHAR_LF) begin
                        label_char = 8'h0a;
                end else if (in_label && code_ok) begin
                        label_char = report_pkg::LABEL_TABLE[code][char_pos];
                end else begin
                        label_char = 8'h20;     // codes 14, 15 and stray positions
                end
        end

endmodule

// ==== verilog/report_sequencer.sv ====
`timescale 1ns/1ns

module report_sequencer (
        input  logic                            sys_clk,
        input  logic                            rst_n,
        input  report_pkg::report_set_t         records,
        output report_pkg::class_code_t         label_code,
        output logic [report_pkg::POS_W-1:0]    char_pos,
        input  logic [7:0]                      label_char,
        output report_pkg::tx_req_t             tx_req,
        input  logic                            tx_ready
);

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_SEND,
                ST_GAP
        } state_t;

        state_t                                 state;
        report_pkg::report_set_t                rec_q;
        logic [report_pkg::REC_IDX_W-1:0]       rec_idx;
        logic [report_pkg::POS_W-1:0]           byte_pos;
        logic [report_pkg::GAP_CNT_W-1:0]       gap_cnt;
        logic                                   valid_q;
        logic [7:0]                             tx_byte;
        logic                                   accept;
        logic                                   rec_end;
        logic                                   last_byte;
        logic                                   gap_done;
        logic                                   capture;

        assign accept    = valid_q && tx_ready;
        assign rec_end   = byte_pos == report_pkg::POS_LAST;
        assign last_byte = rec_end && (rec_idx == report_pkg::REC_LAST);
        assign gap_done  = tx_ready && (gap_cnt == report_pkg::GAP_LAST);

        // records latched once per report
        assign capture = (state == ST_IDLE) || ((state == ST_GAP) && gap_done);

        assign label_code = rec_q[rec_idx].code;
        assign char_pos   = (byte_pos >= report_pkg::POS_LABEL) ?
                            byte_pos - report_pkg::POS_LABEL : '0;

        // tag, two spaces, then label text with cr lf
        always_comb begin
                if (byte_pos == '0) begin
                        tx_byte = rec_q[rec_idx].tag;
                end else if (byte_pos < report_pkg::POS_LABEL) begin
                        tx_byte = 8'h20;
                end else begin
                        tx_byte = label_char;
                end
        end

        assign tx_req = '{valid: valid_q, data: tx_byte};

        always_ff @(posedge sys_clk) begin
                if (capture) begin
                        rec_q <= records;
                end
        end

        always_ff @(posedge sys_clk or negedge rst_n) begin
                if (!rst_n) begin
                        state    <= ST_IDLE;
                        rec_idx  <= '0;
                        byte_pos <= '0;
                        gap_cnt  <= '0;
                        valid_q  <= 1'b0;
                end else begin
                        case (state)
                        ST_IDLE: begin
                                valid_q <= 1'b1;
                                state   <= ST_SEND;
                        end
                        ST_SEND: begin
                                if (accept) begin
                                        if (last_byte) begin
                                                rec_idx  <= '0;
                                                byte_pos <= '0;
                                                gap_cnt  <= '0;
                                                valid_q  <= 1'b0;
                                                state    <= ST_GAP;
                                        end else if (rec_end) begin
                                                rec_idx  <= rec_idx + 1'b1;
                                                byte_pos <= '0;
                                        end else begin
                                                byte_pos <= byte_pos + 1'b1;
                                        end
                                end
                        end
                        ST_GAP: begin
                                // count starts once the last stop bit is out
                                if (!tx_ready) begin
                                        gap_cnt <= '0;
                                end else if (gap_done) begin
                                        gap_cnt <= '0;
                                        valid_q <= 1'b1;
                                        state   <= ST_SEND;
                                end else begin
                                        gap_cnt <= gap_cnt + 1'b1;
                                end
                        end
                        default: begin
                                valid_q <= 1'b0;
                                state   <= ST_IDLE;
                        end
                        endcase
                end
        end

endmodule

// ==== verilog/uart_serializer.sv ====
`timescale 1ns/1ns

module uart_serializer (
        input  logic                    sys_clk,
        input  logic                    rst_n,
        input  report_pkg::tx_req_t     tx_req,
        output logic                    tx_ready,
        output logic                    uart_tx
);

        logic                                   busy;
        logic [report_pkg::BAUD_CNT_W-1:0]      baud_cnt;
        logic [3:0]                             bit_idx;        // 0 start, 1-8 data, 9 stop
        logic [8:0]                             shift_q;        // stop bit above the data
        logic                                   bit_end;
        logic                                   load;

        assign tx_ready = !busy;
        assign load     = !busy && tx_req.valid;
        assign bit_end  = baud_cnt == report_pkg::BAUD_LAST;

        always_ff @(posedge sys_clk) begin
                if (load) begin
                        shift_q <= {1'b1, tx_req.data};
                end else if (busy && bit_end) begin
                        shift_q <= {1'b1, shift_q[8:1]};        // lsb first
                end
        end

        always_ff @(posedge sys_clk or negedge rst_n) begin
                if (!rst_n) begin
                        busy     <= 1'b0;
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        uart_tx  <= 1'b1;
                end else if (!busy) begin
                        if (tx_req.valid) begin
                                busy     <= 1'b1;
                                baud_cnt <= '0;
                                bit_idx  <= '0;
                                uart_tx  <= 1'b0;       // start bit
                        end
                end else if (!bit_end) begin
                        baud_cnt <= baud_cnt + 1'b1;
                end else begin
                        baud_cnt <= '0;
                        if (bit_idx == 4'd9) begin
                                busy <= 1'b0;           // stop bit done, line stays high
                        end else begin
                                bit_idx <= bit_idx + 1'b1;
                                uart_tx <= shift_q[0];
                        end
                end
        end

endmodule

// ==== verilog/uart_report_top.sv ====
`timescale 1ns/1ns

module uart_report_top (
        input  logic                            sys_clk,
        input  logic                            rst_n,
        input  report_pkg::report_set_t         records,
        output logic                            uart_tx
);

        report_pkg::class_code_t                label_code;
        logic [report_pkg::POS_W-1:0]           char_pos;
        logic [7:0]                             label_char;
        report_pkg::tx_req_t                    tx_req;
        logic                                   tx_ready;

        label_rom u_label_rom (
                .code           (label_code),
                .char_pos       (char_pos),
                .label_char     (label_char)
        );

        report_sequencer u_report_sequencer (
                .sys_clk        (sys_clk),
                .rst_n          (rst_n),
                .records        (records),
                .label_code     (label_code),
                .char_pos       (char_pos),
                .label_char     (label_char),
                .tx_req         (tx_req),
                .tx_ready       (tx_ready)
        );

        uart_serializer u_uart_serializer (
                .sys_clk        (sys_clk),
                .rst_n          (rst_n),
                .tx_req         (tx_req),
                .tx_ready       (tx_ready),
                .uart_tx        (uart_tx)
        );

endmodule

// ==== tb/uart_report_properties.sv ====
`timescale 1ns/1ns

module uart_report_properties (
        input  logic                                    sys_clk,
        input  logic                                    rst_n,
        input  report_pkg::tx_req_t                     tx_req,
        input  logic                                    tx_ready,
        input  logic [report_pkg::REC_IDX_W-1:0]        rec_idx,
        input  logic [report_pkg::POS_W-1:0]            byte_pos
);

        int unsigned fail_cnt = 0;      // read by the testbench

        // offered byte waits for the serializer
        a_valid_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
                (tx_req.valid && !tx_ready) |=> (tx_req.valid && $stable(tx_req.data)))
                else begin
                        fail_cnt++;
                        $error("tx_req dropped or changed before the serializer took it");
                end

        a_rec_idx: assert property (@(posedge sys_clk) disable iff (!rst_n)
                rec_idx < report_pkg::NUM_RECORDS)
                else begin
                        fail_cnt++;
                        $error("record index ran past the last record");
                end

        a_byte_pos: assert property (@(posedge sys_clk) disable iff (!rst_n)
                byte_pos < report_pkg::RECORD_LEN)
                else begin
                        fail_cnt++;
                        $error("byte position ran past the end of a record");
                end

endmodule

bind report_sequencer uart_report_properties u_props (
        .sys_clk        (sys_clk),
        .rst_n          (rst_n),
        .tx_req         (tx_req),
        .tx_ready       (tx_ready),
        .rec_idx        (rec_idx),
        .byte_pos       (byte_pos)
);

// ==== tb/tb_uart_report.sv ====
`timescale 1ns/1ns

module tb_uart_report;

        localparam int CLK_NS       = 10;
        localparam int BIT_NS       = report_pkg::CLKS_PER_BIT * CLK_NS;
        localparam int GUARD_NS     = CLK_NS + 3;       // one clock off the bit edge
        localparam int NUM_REPORTS  = 4;
        localparam int REPORT_BYTES = report_pkg::NUM_RECORDS * report_pkg::RECORD_LEN;
        localparam int SWAP_AT      = 40;               // mid-report input change
        localparam int GAP_NS       = report_pkg::REPORT_GAP_CYCLES * CLK_NS;

        // one report: bytes with a few clocks between them, then the gap
        localparam longint REPORT_NS = longint'(REPORT_BYTES) * (10 * BIT_NS + 4 * CLK_NS)
                                       + longint'(GAP_NS + 10 * CLK_NS);
        localparam longint LIMIT_NS  = (NUM_REPORTS + 1) * REPORT_NS + 100_000;

        logic                           sys_clk;
        logic                           rst_n;
        report_pkg::report_set_t        records;
        logic                           uart_tx;

        logic [31:0]                    rng_state;
        report_pkg::report_set_t        exp_set [0:NUM_REPORTS];
        int                             byte_count;

        uart_report_top u_uart_report_top (
                .sys_clk        (sys_clk),
                .rst_n          (rst_n),
                .records        (records),
                .uart_tx        (uart_tx)
        );

        initial sys_clk = 1'b0;
        always #(CLK_NS / 2) sys_clk = ~sys_clk;

        task automatic abort_run();
                $display("Something failed");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
                if (got !== expected) begin
                        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                 name, got, expected);
                        abort_run();
                end
        endtask

        function automatic logic [31:0] xorshift32(input logic [31:0] s);
                logic [31:0] x;
                x = s;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        function automatic logic [31:0] next_rand();
                rng_state = xorshift32(rng_state);
                return rng_state;
        endfunction

        function automatic report_pkg::report_set_t random_set(input int rpt);
                report_pkg::report_set_t s;
                logic [31:0]             r;
                for (int i = 0; i < report_pkg::NUM_RECORDS; i++) begin
                        r         = next_rand();
                        s[i].tag  = r[7:0];
                        s[i].code = r[11:8];
                end
                // each blank code lands in some report
                case (rpt)
                0: s[0].code = 4'd0;
                1: s[1].code = 4'd14;
                2: s[2].code = 4'd15;
                default: ;
                endcase
                return s;
        endfunction

        // byte n of a report: tag, two spaces, label, cr lf
        function automatic logic [7:0] model_byte(input report_pkg::report_set_t s,
                                                  input int n);
                int          rec;
                int          pos;
                logic [3:0]  code;
                logic [7:0]  b;
                rec  = n / report_pkg::RECORD_LEN;
                pos  = n % report_pkg::RECORD_LEN;
                code = s[rec].code;
                if (pos == 0) begin
                        b = s[rec].tag;
                end else if (pos < 3) begin
                        b = 8'h20;
                end else if (pos == report_pkg::RECORD_LEN - 2) begin
                        b = 8'h0d;
                end else if (pos == report_pkg::RECORD_LEN - 1) begin
                        b = 8'h0a;
                end else if (code == 4'd0 || code >= report_pkg::NUM_LABELS) begin
                        b = 8'h20;
                end else begin
                        b = report_pkg::LABEL_TABLE[code][pos - 3];
                end
                return b;
        endfunction

        // waits for a start bit, samples each bit near both ends and in the middle
        task automatic receive_byte(output logic [7:0] data, output time t_start);
                logic [9:0] bits;
                logic       early;
                logic       late;
                @(negedge uart_tx);
                t_start = $time;
                for (int i = 0; i < 10; i++) begin
                        #(GUARD_NS);
                        early = uart_tx;
                        #(BIT_NS / 2 + 3 - GUARD_NS);
                        bits[i] = uart_tx;
                        #(BIT_NS / 2 - 3 - GUARD_NS);
                        late = uart_tx;
                        if (early !== bits[i] || late !== bits[i]) begin
                                $display("uart_tx changed level inside bit %0d of a byte", i);
                                abort_run();
                        end
                        if (i < 9) begin
                                #(GUARD_NS);
                        end
                end
                check("uart_tx start bit", bits[0], 1'b0);
                check("uart_tx stop bit", bits[9], 1'b1);
                data = bits[8:1];
        endtask

        // main flow: reset, then four reports decoded and compared
        initial begin
                logic [7:0] got;
                time        t_start;
                time        t_stop_end;
                rng_state  = 32'h99b1;
                rst_n      = 1'b0;
                byte_count = 0;
                t_stop_end = 0;
                exp_set[0] = random_set(0);
                records    = exp_set[0];
                repeat (3) begin
                        @(negedge sys_clk);
                        check("uart_tx during reset", uart_tx, 1'b1);
                end
                rst_n = 1'b1;
                for (int rpt = 0; rpt < NUM_REPORTS; rpt++) begin
                        for (int n = 0; n < REPORT_BYTES; n++) begin
                                receive_byte(got, t_start);
                                if (rpt > 0 && n == 0 && (t_start - t_stop_end) < GAP_NS) begin
                                        $display("line idle for only %0d ns between reports",
                                                 t_start - t_stop_end);
                                        abort_run();
                                end
                                check($sformatf("uart_tx byte %0d of report %0d", n, rpt),
                                      got, model_byte(exp_set[rpt], n));
                                byte_count++;
                        end
                        t_stop_end = t_start + 10 * BIT_NS;
                end
                if (u_uart_report_top.u_report_sequencer.u_props.fail_cnt == 0) begin
                        $display("Everything OK");
                        $finish;
                end else begin
                        $display("assertion failed in the report sequencer");
                        abort_run();
                end
        end

        // new records part way through each report, used by the next one
        initial begin
                for (int rpt = 0; rpt < NUM_REPORTS; rpt++) begin
                        wait (byte_count == rpt * REPORT_BYTES + SWAP_AT);
                        @(negedge sys_clk);
                        exp_set[rpt + 1] = random_set(rpt + 1);
                        records          = exp_set[rpt + 1];
                end
        end

        always @(u_uart_report_top.u_report_sequencer.u_props.fail_cnt) begin
                if (u_uart_report_top.u_report_sequencer.u_props.fail_cnt != 0) begin
                        $display("assertion failed in the report sequencer");
                        abort_run();
                end
        end

        initial begin
                #(LIMIT_NS);
                $display("watchdog expired before all reports were received");
                abort_run();
        end

endmodule

// ==== project.f ====
verilog/report_pkg.sv
verilog/label_rom.sv
verilog/report_sequencer.sv
verilog/uart_serializer.sv
verilog/uart_report_top.sv
tb/uart_report_properties.sv
tb/tb_uart_report.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_uart_report
RTL_TOP    := uart_report_top
FILELIST   := project.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
RUN_FLAGS  := +verilator+error+limit+100
PASS_MSG   := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
